// ==== design/dma_len_counter.sv ====
`timescale 1ns/1ps

module dma_len_counter #(
   parameter int DATA_WIDTH     = 64,
   parameter int RAM_ADDR_WIDTH = 10
) (
   input  logic                                clk,
   input  logic                                rst,

   input  logic                                desc_load,
   input  logic [dma_pkg::PCIE_ADDR_WIDTH-1:0] read_desc_pcie_addr,
   input  logic [RAM_ADDR_WIDTH-1:0]           read_desc_ram_addr,
   input  logic [dma_pkg::LEN_WIDTH-1:0]       read_desc_len,

   input  logic [dma_pkg::MRRS_WIDTH-1:0]      max_read_request_size,

   input  logic                                req_fire,
   input  logic                                cpl_valid,

   output logic [dma_pkg::PCIE_ADDR_WIDTH-1:0] rd_req_addr,
   output logic [dma_pkg::LEN_WIDTH-1:0]       rd_req_len,
   output logic                                len_zero,
   output logic                                last_chunk,
   output logic                                cpl_last,
   output logic [RAM_ADDR_WIDTH-1:0]           ram_wr_addr
);

   import dma_pkg::*;

   // host bytes per RAM word
   localparam int WORD_BYTES = DATA_WIDTH / 8;

   logic [MRRS_WIDTH-1:0]      mrrs_code;
   logic [LEN_WIDTH-1:0]       max_req_words;
   logic [LEN_WIDTH-1:0]       remaining;
   logic [LEN_WIDTH-1:0]       chunk_len;
   logic [LEN_WIDTH-1:0]       cpl_count;
   logic [PCIE_ADDR_WIDTH-1:0] chunk_bytes;

   // codes 6 and 7 behave like 5
   assign mrrs_code = (max_read_request_size > MRRS_WIDTH'(MRRS_CODE_MAX)) ?
                      MRRS_WIDTH'(MRRS_CODE_MAX) : max_read_request_size;

   assign max_req_words = LEN_WIDTH'(BASE_READ_REQ_WORDS) << mrrs_code;

   // current chunk, stable while the request waits for ready
   assign rd_req_len = (remaining < max_req_words) ? remaining : max_req_words;

   assign len_zero = (remaining == '0);

   assign chunk_bytes = PCIE_ADDR_WIDTH'(rd_req_len) * PCIE_ADDR_WIDTH'(WORD_BYTES);

   // final word of the request in flight
   assign cpl_last = cpl_valid && (cpl_count == chunk_len - LEN_WIDTH'(1));

   always_ff @(posedge clk) begin
      if (rst) begin
         remaining  <= '0;
         chunk_len  <= '0;
         last_chunk <= 1'b0;
      end else if (desc_load) begin
         remaining  <= read_desc_len;
         last_chunk <= 1'b0;
      end else if (req_fire) begin
         remaining  <= remaining - rd_req_len;
         chunk_len  <= rd_req_len;
         last_chunk <= (remaining == rd_req_len);
      end
   end

   // word count within the chunk
   always_ff @(posedge clk) begin
      if (rst) begin
         cpl_count <= '0;
      end else if (req_fire || cpl_last) begin
         cpl_count <= '0;
      end else if (cpl_valid) begin
         cpl_count <= cpl_count + LEN_WIDTH'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (desc_load) begin
         rd_req_addr <= read_desc_pcie_addr;
      end else if (req_fire) begin
         rd_req_addr <= rd_req_addr + chunk_bytes;
      end
   end

   // wraps at the RAM size
   always_ff @(posedge clk) begin
      if (desc_load) begin
         ram_wr_addr <= read_desc_ram_addr;
      end else if (cpl_valid) begin
         ram_wr_addr <= ram_wr_addr + RAM_ADDR_WIDTH'(1);
      end
   end

endmodule

// ==== design/dma_pkg.sv ====
package dma_pkg;

   localparam int PCIE_ADDR_WIDTH    = 64;
   localparam int LEN_WIDTH          = 16;
   localparam int TAG_WIDTH          = 8;
   localparam int STATUS_ERROR_WIDTH = 4;

   // max read request size, encoded as in the PCIe device control register
   localparam int MRRS_WIDTH          = 3;
   localparam int MRRS_CODE_MAX       = 5;
   localparam int BASE_READ_REQ_WORDS = 16;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_START,
      ST_ISSUE,
      ST_WAIT_CPL,
      ST_STATUS
   } dma_state_t;

   // status codes on read_desc_status_error
   typedef enum logic [STATUS_ERROR_WIDTH-1:0] {
      DMA_ERROR_NONE    = 0,
      DMA_ERROR_CPL     = 1,
      DMA_ERROR_BAD_LEN = 2
   } dma_error_t;

endpackage

// ==== design/dma_psdpram.sv ====
`timescale 1ns/1ps

module dma_psdpram #(
   parameter int DATA_WIDTH     = 64,
   parameter int RAM_ADDR_WIDTH = 10,
   parameter int RAM_PIPELINE   = 2
) (
   input  logic                      clk,
   input  logic                      rst,

   input  logic                      wr_en,
   input  logic [RAM_ADDR_WIDTH-1:0] wr_addr,
   input  logic [DATA_WIDTH-1:0]     wr_data,

   input  logic                      rd_en,
   input  logic [RAM_ADDR_WIDTH-1:0] rd_addr,
   output logic [DATA_WIDTH-1:0]     rd_data,
   output logic                      rd_valid
);

   logic [DATA_WIDTH-1:0] mem [2**RAM_ADDR_WIDTH];

   logic [DATA_WIDTH-1:0] data_pipe  [RAM_PIPELINE];
   logic [RAM_PIPELINE-1:0] valid_pipe;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // stage 0 reads the array and the rest are output registers
   always_ff @(posedge clk) begin
      if (rd_en) begin
         data_pipe[0] <= mem[rd_addr];
      end
      for (int i = 1; i < RAM_PIPELINE; i++) begin
         data_pipe[i] <= data_pipe[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_pipe <= '0;
      end else begin
         valid_pipe <= RAM_PIPELINE'({valid_pipe, rd_en});
      end
   end

   assign rd_data  = data_pipe[RAM_PIPELINE-1];
   assign rd_valid = valid_pipe[RAM_PIPELINE-1];

endmodule

// ==== design/dma_read_fsm.sv ====
`timescale 1ns/1ps

module dma_read_fsm (
   input  logic                          clk,
   input  logic                          rst,

   input  logic                          read_desc_valid,
   input  logic [dma_pkg::TAG_WIDTH-1:0] read_desc_tag,
   output logic                          read_desc_ready,

   // from the length counter
   input  logic                          len_zero,
   input  logic                          cpl_last,
   input  logic                          last_chunk,
   output logic                          desc_load,
   output logic                          req_fire,

   input  logic                          cpl_valid,
   input  logic                          cpl_error,

   input  logic                          rd_req_ready,
   output logic                          rd_req_valid,

   output logic [dma_pkg::TAG_WIDTH-1:0] read_desc_status_tag,
   output dma_pkg::dma_error_t           read_desc_status_error,
   output logic                          read_desc_status_valid
);

   import dma_pkg::*;

   dma_state_t state;
   dma_state_t state_next;

   // outputs decoded from the state register
   assign read_desc_ready        = (state == ST_IDLE);
   assign rd_req_valid           = (state == ST_ISSUE);
   assign read_desc_status_valid = (state == ST_STATUS);

   assign desc_load = read_desc_valid && read_desc_ready;
   assign req_fire  = rd_req_valid && rd_req_ready;

   always_comb begin
      state_next = state;
      case (state)
         ST_IDLE: begin
            if (read_desc_valid) begin
               state_next = ST_START;
            end
         end
         ST_START: begin
            // counter is loaded by now, so len_zero is valid
            if (len_zero) begin
               state_next = ST_STATUS;
            end else begin
               state_next = ST_ISSUE;
            end
         end
         ST_ISSUE: begin
            if (rd_req_ready) begin
               state_next = ST_WAIT_CPL;
            end
         end
         ST_WAIT_CPL: begin
            if (cpl_last) begin
               if (last_chunk) begin
                  state_next = ST_STATUS;
               end else begin
                  state_next = ST_ISSUE;
               end
            end
         end
         ST_STATUS: begin
            state_next = ST_IDLE;
         end
         default: begin
            state_next = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // sticky error, cleared per descriptor
   always_ff @(posedge clk) begin
      if (rst) begin
         read_desc_status_error <= DMA_ERROR_NONE;
      end else if (desc_load) begin
         read_desc_status_error <= DMA_ERROR_NONE;
      end else if (state == ST_START && len_zero) begin
         read_desc_status_error <= DMA_ERROR_BAD_LEN;
      end else if (state == ST_WAIT_CPL && cpl_valid && cpl_error) begin
         read_desc_status_error <= DMA_ERROR_CPL;
      end
   end

   always_ff @(posedge clk) begin
      if (desc_load) begin
         read_desc_status_tag <= read_desc_tag;
      end
   end

endmodule

// ==== design/pcie_dma_read.sv ====
`timescale 1ns/1ps

module pcie_dma_read #(
   parameter int DATA_WIDTH     = 64,
   parameter int RAM_ADDR_WIDTH = 10,
   parameter int RAM_PIPELINE   = 2
) (
   input  logic                                clk,
   input  logic                                rst,

   // read descriptor
   input  logic [dma_pkg::PCIE_ADDR_WIDTH-1:0] read_desc_pcie_addr,
   input  logic [RAM_ADDR_WIDTH-1:0]           read_desc_ram_addr,
   input  logic [dma_pkg::LEN_WIDTH-1:0]       read_desc_len,
   input  logic [dma_pkg::TAG_WIDTH-1:0]       read_desc_tag,
   input  logic                                read_desc_valid,
   output logic                                read_desc_ready,

   // descriptor status
   output logic [dma_pkg::TAG_WIDTH-1:0]       read_desc_status_tag,
   output dma_pkg::dma_error_t                 read_desc_status_error,
   output logic                                read_desc_status_valid,

   input  logic [dma_pkg::MRRS_WIDTH-1:0]      max_read_request_size,

   // host read request
   output logic [dma_pkg::PCIE_ADDR_WIDTH-1:0] rd_req_addr,
   output logic [dma_pkg::LEN_WIDTH-1:0]       rd_req_len,
   output logic                                rd_req_valid,
   input  logic                                rd_req_ready,

   // completion words, in order
   input  logic [DATA_WIDTH-1:0]               cpl_data,
   input  logic                                cpl_error,
   input  logic                                cpl_valid,

   input  logic                                ram_rd_en,
   input  logic [RAM_ADDR_WIDTH-1:0]           ram_rd_addr,
   output logic [DATA_WIDTH-1:0]               ram_rd_data,
   output logic                                ram_rd_valid
);

   logic                      desc_load;
   logic                      req_fire;
   logic                      len_zero;
   logic                      last_chunk;
   logic                      cpl_last;
   logic [RAM_ADDR_WIDTH-1:0] ram_wr_addr;

   dma_read_fsm fsm_inst (
      .clk                    (clk),
      .rst                    (rst),
      .read_desc_valid        (read_desc_valid),
      .read_desc_tag          (read_desc_tag),
      .read_desc_ready        (read_desc_ready),
      .len_zero               (len_zero),
      .cpl_last               (cpl_last),
      .last_chunk             (last_chunk),
      .desc_load              (desc_load),
      .req_fire               (req_fire),
      .cpl_valid              (cpl_valid),
      .cpl_error              (cpl_error),
      .rd_req_ready           (rd_req_ready),
      .rd_req_valid           (rd_req_valid),
      .read_desc_status_tag   (read_desc_status_tag),
      .read_desc_status_error (read_desc_status_error),
      .read_desc_status_valid (read_desc_status_valid)
   );

   dma_len_counter #(
      .DATA_WIDTH     (DATA_WIDTH),
      .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
   ) counter_inst (
      .clk                   (clk),
      .rst                   (rst),
      .desc_load             (desc_load),
      .read_desc_pcie_addr   (read_desc_pcie_addr),
      .read_desc_ram_addr    (read_desc_ram_addr),
      .read_desc_len         (read_desc_len),
      .max_read_request_size (max_read_request_size),
      .req_fire              (req_fire),
      .cpl_valid             (cpl_valid),
      .rd_req_addr           (rd_req_addr),
      .rd_req_len            (rd_req_len),
      .len_zero              (len_zero),
      .last_chunk            (last_chunk),
      .cpl_last              (cpl_last),
      .ram_wr_addr           (ram_wr_addr)
   );

   // completion words go straight into the card RAM
   dma_psdpram #(
      .DATA_WIDTH     (DATA_WIDTH),
      .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
      .RAM_PIPELINE   (RAM_PIPELINE)
   ) ram_inst (
      .clk      (clk),
      .rst      (rst),
      .wr_en    (cpl_valid),
      .wr_addr  (ram_wr_addr),
      .wr_data  (cpl_data),
      .rd_en    (ram_rd_en),
      .rd_addr  (ram_rd_addr),
      .rd_data  (ram_rd_data),
      .rd_valid (ram_rd_valid)
   );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the pcie_dma_read testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal \
   --top-module tb_pcie_dma_read \
   --Mdir obj_dir -o sim_pcie_dma_read \
   -f verilog.f

./obj_dir/sim_pcie_dma_read

// ==== testbench/tb_host_model.sv ====
`timescale 1ns/1ps

module tb_host_model #(
   parameter logic [31:0] SEED = 32'hd159_ddf9
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [63:0] rd_req_addr,
   input  logic [15:0] rd_req_len,
   input  logic        rd_req_valid,
   output logic        rd_req_ready,
   output logic [63:0] cpl_data,
   output logic        cpl_error,
   output logic        cpl_valid,
   input  logic [63:0] bad_addr,
   input  logic        bad_en
);

   integer      seed;
   logic        busy;
   logic [63:0] word_addr;
   int          words_left;
   int          gap;

   // host memory contents, a function of the byte address
   function automatic logic [63:0] word_pattern(input logic [63:0] byte_addr);
      return (byte_addr * 64'h9e37_79b9_7f4a_7c15) ^ {byte_addr[31:0], byte_addr[63:32]};
   endfunction

   initial begin
      seed = SEED;
      busy = 1'b0;
      word_addr = '0;
      words_left = 0;
      gap = 0;
      rd_req_ready <= 1'b0;
      cpl_data <= '0;
      cpl_error <= 1'b0;
      cpl_valid <= 1'b0;
      forever begin
         @(posedge clk);
         cpl_valid <= 1'b0;
         if (rst) begin
            busy = 1'b0;
            rd_req_ready <= 1'b0;
         end else if (!busy) begin
            if (rd_req_valid && rd_req_ready) begin
               busy = 1'b1;
               word_addr = rd_req_addr;
               words_left = int'(rd_req_len);
               gap = $random(seed) & 3;
               rd_req_ready <= 1'b0;
            end else begin
               rd_req_ready <= 1'($random(seed) & 1);
            end
         end else if (gap > 0) begin
            gap = gap - 1;
         end else begin
            // one completion word, then a random gap
            cpl_valid <= 1'b1;
            cpl_data <= word_pattern(word_addr);
            cpl_error <= bad_en && (word_addr == bad_addr);
            word_addr = word_addr + 64'd8;
            words_left = words_left - 1;
            gap = $random(seed) & 3;
            if (words_left == 0) begin
               busy = 1'b0;
            end
         end
      end
   end

endmodule

// ==== testbench/tb_pcie_dma_read.sv ====
`timescale 1ns/1ps

module tb_pcie_dma_read;

   import dma_pkg::*;

   localparam int          DATA_WIDTH     = 64;
   localparam int          RAM_ADDR_WIDTH = 10;
   localparam int          RAM_PIPELINE   = 2;
   localparam int          NUM_DESC       = 40;
   localparam logic [31:0] SEED           = 32'hd159_ddf9;

   logic                       clk;
   logic                       rst;
   logic [PCIE_ADDR_WIDTH-1:0] read_desc_pcie_addr;
   logic [RAM_ADDR_WIDTH-1:0]  read_desc_ram_addr;
   logic [LEN_WIDTH-1:0]       read_desc_len;
   logic [TAG_WIDTH-1:0]       read_desc_tag;
   logic                       read_desc_valid;
   logic                       read_desc_ready;
   logic [TAG_WIDTH-1:0]       read_desc_status_tag;
   dma_error_t                 read_desc_status_error;
   logic                       read_desc_status_valid;
   logic [MRRS_WIDTH-1:0]      max_read_request_size;
   logic [PCIE_ADDR_WIDTH-1:0] rd_req_addr;
   logic [LEN_WIDTH-1:0]       rd_req_len;
   logic                       rd_req_valid;
   logic                       rd_req_ready;
   logic [DATA_WIDTH-1:0]      cpl_data;
   logic                       cpl_error;
   logic                       cpl_valid;
   logic                       ram_rd_en;
   logic [RAM_ADDR_WIDTH-1:0]  ram_rd_addr;
   logic [DATA_WIDTH-1:0]      ram_rd_data;
   logic                       ram_rd_valid;
   logic [63:0]                bad_addr;
   logic                       bad_en;

   integer                     seed;

   // reference model state
   logic [DATA_WIDTH-1:0]      shadow [2**RAM_ADDR_WIDTH];
   logic                       in_flight;
   int                         remaining;
   logic [63:0]                next_addr;
   logic [TAG_WIDTH-1:0]       exp_tag;
   dma_error_t                 exp_error;
   logic                       req_held;
   logic [63:0]                held_addr;
   logic [LEN_WIDTH-1:0]       held_len;
   int                         code;
   int                         exp_len;
   logic [63:0]                bad_off;
   logic [RAM_ADDR_WIDTH-1:0]  idx;

   pcie_dma_read #(
      .DATA_WIDTH     (DATA_WIDTH),
      .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
      .RAM_PIPELINE   (RAM_PIPELINE)
   ) uut (
      .clk(clk), .rst(rst),
      .read_desc_pcie_addr(read_desc_pcie_addr), .read_desc_ram_addr(read_desc_ram_addr),
      .read_desc_len(read_desc_len), .read_desc_tag(read_desc_tag),
      .read_desc_valid(read_desc_valid), .read_desc_ready(read_desc_ready),
      .read_desc_status_tag(read_desc_status_tag),
      .read_desc_status_error(read_desc_status_error),
      .read_desc_status_valid(read_desc_status_valid),
      .max_read_request_size(max_read_request_size),
      .rd_req_addr(rd_req_addr), .rd_req_len(rd_req_len),
      .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
      .cpl_data(cpl_data), .cpl_error(cpl_error), .cpl_valid(cpl_valid),
      .ram_rd_en(ram_rd_en), .ram_rd_addr(ram_rd_addr),
      .ram_rd_data(ram_rd_data), .ram_rd_valid(ram_rd_valid)
   );

   tb_host_model #(
      .SEED (SEED)
   ) host (
      .clk(clk), .rst(rst),
      .rd_req_addr(rd_req_addr), .rd_req_len(rd_req_len),
      .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
      .cpl_data(cpl_data), .cpl_error(cpl_error), .cpl_valid(cpl_valid),
      .bad_addr(bad_addr), .bad_en(bad_en)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // same host memory contents as the host model
   function automatic logic [63:0] word_pattern(input logic [63:0] byte_addr);
      return (byte_addr * 64'h9e37_79b9_7f4a_7c15) ^ {byte_addr[31:0], byte_addr[63:32]};
   endfunction

   task automatic fail_run(input string line);
      $display("%s", line);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                        input string what);
      if (actual !== expected) begin
         fail_run($sformatf("Mismatch at time %0t: %s, got 0x%0h, expected 0x%0h",
                            $time, what, actual, expected));
      end
   endtask

   task automatic wait_accept();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > 50) fail_run("Timeout: the descriptor was never accepted");
      end while (!read_desc_ready);
   endtask

   task automatic wait_status(output int cycles);
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > 20000) fail_run("Timeout: no status pulse for the descriptor");
      end while (!read_desc_status_valid);
   endtask

   task automatic read_ram_word(input logic [RAM_ADDR_WIDTH-1:0] addr);
      int cycles;
      ram_rd_en <= 1'b1;
      ram_rd_addr <= addr;
      @(posedge clk);
      ram_rd_en <= 1'b0;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > 8) fail_run("Timeout: RAM read never returned ram_rd_valid");
      end while (!ram_rd_valid);
      check(64'(cycles), 64'(RAM_PIPELINE), "ram_rd_valid latency");
      check(ram_rd_data, shadow[addr], $sformatf("RAM word at 0x%0h", addr));
   endtask

   // monitor and reference model, sampled on the rising edge
   always @(posedge clk) begin
      if (rst) begin
         in_flight = 1'b0;
         remaining = 0;
         req_held = 1'b0;
      end else begin
         if (in_flight) check(64'(read_desc_ready), 64'd0, "read_desc_ready while busy");
         if (req_held) begin
            check(64'(rd_req_valid), 64'd1, "rd_req_valid dropped before ready");
            check(rd_req_addr, held_addr, "rd_req_addr under back-pressure");
            check(64'(rd_req_len), 64'(held_len), "rd_req_len under back-pressure");
         end
         req_held = rd_req_valid && !rd_req_ready;
         held_addr = rd_req_addr;
         held_len = rd_req_len;
         if (rd_req_valid) check(64'(remaining != 0), 64'd1, "request with no words left");
         if (rd_req_valid && rd_req_ready) begin
            code = int'(max_read_request_size);
            if (code > MRRS_CODE_MAX) code = MRRS_CODE_MAX;
            exp_len = BASE_READ_REQ_WORDS << code;
            if (remaining < exp_len) exp_len = remaining;
            check(64'(rd_req_len), 64'(exp_len), "rd_req_len");
            check(rd_req_addr, next_addr, "rd_req_addr");
            remaining = remaining - exp_len;
            next_addr = next_addr + 64'(exp_len) * 64'd8;
         end
         if (read_desc_status_valid) begin
            check(64'(in_flight), 64'd1, "status pulse without an open descriptor");
            check(64'(read_desc_status_tag), 64'(exp_tag), "status tag");
            check(64'(read_desc_status_error), 64'(exp_error), "status error");
            check(64'(remaining), 64'd0, "requested words against descriptor length");
            in_flight = 1'b0;
         end
         if (read_desc_valid && read_desc_ready) begin
            in_flight = 1'b1;
            remaining = int'(read_desc_len);
            next_addr = read_desc_pcie_addr;
            exp_tag = read_desc_tag;
            bad_off = bad_addr - read_desc_pcie_addr;
            if (read_desc_len == '0) begin
               exp_error = DMA_ERROR_BAD_LEN;
            end else if (bad_en && bad_off[2:0] == 3'd0 && (bad_off >> 3) < 64'(read_desc_len)) begin
               exp_error = DMA_ERROR_CPL;
            end else begin
               exp_error = DMA_ERROR_NONE;
            end
            for (int i = 0; i < int'(read_desc_len); i++) begin
               idx = read_desc_ram_addr + RAM_ADDR_WIDTH'(i);
               shadow[idx] = word_pattern(read_desc_pcie_addr + 64'(i) * 64'd8);
            end
         end
      end
   end

   initial begin
      logic [63:0]               addr;
      logic [RAM_ADDR_WIDTH-1:0] ram_addr;
      logic [LEN_WIDTH-1:0]      len;
      logic [31:0]               r;
      int                        cycles;
      seed = SEED;
      rst <= 1'b1;
      read_desc_pcie_addr <= '0;
      read_desc_ram_addr <= '0;
      read_desc_len <= '0;
      read_desc_tag <= '0;
      read_desc_valid <= 1'b0;
      max_read_request_size <= '0;
      ram_rd_en <= 1'b0;
      ram_rd_addr <= '0;
      bad_addr <= '0;
      bad_en <= 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check(64'(read_desc_ready), 64'd1, "read_desc_ready after reset");
      check(64'(rd_req_valid), 64'd0, "rd_req_valid after reset");
      check(64'(read_desc_status_valid), 64'd0, "read_desc_status_valid after reset");
      check(64'(ram_rd_valid), 64'd0, "ram_rd_valid after reset");

      for (int n = 0; n < NUM_DESC; n++) begin
         addr = {32'($random(seed)), 32'($random(seed))} & ~64'h7;
         ram_addr = RAM_ADDR_WIDTH'($random(seed));
         len = (n % 8 == 3) ? '0 : LEN_WIDTH'((($random(seed) & 1023) % 700) + 1);
         r = $random(seed);
         // one flagged word in about half of the transfers
         bad_en <= (len != '0) && r[0];
         if (len != '0) begin
            bad_addr <= addr + {32'd0, (r >> 1) % {16'd0, len}} * 64'd8;
         end
         max_read_request_size <= MRRS_WIDTH'($random(seed));
         read_desc_pcie_addr <= addr;
         read_desc_ram_addr <= ram_addr;
         read_desc_len <= len;
         read_desc_tag <= TAG_WIDTH'($random(seed));
         read_desc_valid <= 1'b1;
         wait_accept();
         read_desc_valid <= 1'b0;
         wait_status(cycles);
         if (len == '0) check(64'(cycles), 64'd2, "zero-length status latency");
         for (int i = 0; i < int'(len); i++) begin
            read_ram_word(ram_addr + RAM_ADDR_WIDTH'(i));
         end
      end

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== verilog.f ====
design/dma_pkg.sv
design/dma_read_fsm.sv
design/dma_len_counter.sv
design/dma_psdpram.sv
design/pcie_dma_read.sv
testbench/tb_host_model.sv
testbench/tb_pcie_dma_read.sv
